// ==== sources.f ====
hw/fetch_mem_pkg.sv
hw/icache_lines.sv
hw/icache_miss_tracker.sv
hw/mem_bus_port.sv
hw/fetch_mem_top.sv
bench/tb_clock_gen.sv
bench/mem_model.sv
bench/fetch_mem_tb.sv

// ==== bench/fetch_mem_tb.sv ====
`timescale 1ns/1ps

module fetch_mem_tb import fetch_mem_pkg::*; ();

  localparam int K_FETCH = 0;   // cold fetch, wait for fetch_valid
  localparam int K_HIT   = 1;   // fetch that must hit at once
  localparam int K_STORE = 2;
  localparam int K_LOAD  = 3;
  localparam int K_RACE  = 4;   // cold fetch plus a data load from the wdata column

  localparam int NUM_ENTRIES = 14;
  localparam int MAX_CYCLES  = 40 * NUM_ENTRIES + 100;

  logic                 clock;
  logic                 reset;
  icache_addr_u         fetch_addr;
  logic [INST_W-1:0]    fetch_inst;
  logic                 fetch_valid;
  logic                 d_req;
  logic [1:0]           d_cmd;
  logic [ADDR_W-1:0]    d_addr;
  logic [DATA_W-1:0]    d_wdata;
  logic                 d_busy;
  logic                 d_done;
  logic [DATA_W-1:0]    d_rdata;
  logic [MEM_TAG_W-1:0] mem2proc_response;
  logic [DATA_W-1:0]    mem2proc_data;
  logic [MEM_TAG_W-1:0] mem2proc_tag;
  logic [1:0]           proc2mem_command;
  logic [ADDR_W-1:0]    proc2mem_addr;
  logic [DATA_W-1:0]    proc2mem_data;

  int                kind_tbl  [NUM_ENTRIES];
  logic [ADDR_W-1:0] addr_tbl  [NUM_ENTRIES];
  logic [DATA_W-1:0] wdata_tbl [NUM_ENTRIES];
  logic [DATA_W-1:0] exp_tbl   [NUM_ENTRIES];
  int                n_entries;
  int                error_count;
  int                cycle_count;
  logic              held_q;
  logic [1:0]        held_cmd;
  logic [ADDR_W-1:0] held_addr;

  tb_clock_gen clk_gen (.clock(clock), .reset(reset));

  fetch_mem_top DUT (.*);

  mem_model mem (
    .clock(clock), .reset(reset),
    .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
    .proc2mem_data(proc2mem_data), .mem2proc_response(mem2proc_response),
    .mem2proc_tag(mem2proc_tag), .mem2proc_data(mem2proc_data)
  );

  function automatic logic [DATA_W-1:0] line_pattern(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] line_a;
    line_a = {addr[ADDR_W-1:3], 3'b000};
    return {~line_a[31:0], line_a[31:0]};
  endfunction

  function automatic logic [INST_W-1:0] inst_of(input logic [ADDR_W-1:0] addr);
    icache_addr_u a;
    logic [31:0]  line_lo;
    a.raw   = addr;
    line_lo = {addr[31:3], 3'b000};
    // unwritten line keeps the inverted address in its upper half
    if (a.f.offset[2]) begin
      return ~line_lo;
    end
    return line_lo;
  endfunction

  task automatic add_entry(input int kind, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp);
    kind_tbl[n_entries]  = kind;
    addr_tbl[n_entries]  = addr;
    wdata_tbl[n_entries] = wdata;
    exp_tbl[n_entries]   = exp;
    n_entries++;
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic issue_data(input logic [1:0] cmd, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
    d_req   = 1'b1;
    d_cmd   = cmd;
    d_addr  = addr;
    d_wdata = wdata;
    @(posedge clock);
    #1 d_req = 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clock);
    while (!d_done) @(negedge clock);
    check_value("d_busy", d_busy, 1'b0);
  endtask

  task automatic check_single_done();
    @(negedge clock);
    check_value("d_done", d_done, 1'b0);
  endtask

  task automatic wait_fetch();
    @(negedge clock);
    while (!fetch_valid) @(negedge clock);
  endtask

  task automatic run_entry(input int i);
    @(posedge clock);
    #1;
    case (kind_tbl[i])
      K_FETCH: begin
        fetch_addr.raw = addr_tbl[i];
        wait_fetch();
        check_value("fetch_inst", fetch_inst, exp_tbl[i]);
      end
      K_HIT: begin
        fetch_addr.raw = addr_tbl[i];
        @(negedge clock);
        check_value("fetch_valid", fetch_valid, 1'b1);
        check_value("fetch_inst", fetch_inst, exp_tbl[i]);
        for (int c = 0; c < 3; c++) begin
          check_value("proc2mem_command", proc2mem_command, BUS_NONE);
          @(negedge clock);
        end
      end
      K_STORE: begin
        issue_data(BUS_STORE, addr_tbl[i], wdata_tbl[i]);
        wait_done();
        check_single_done();
      end
      K_LOAD: begin
        issue_data(BUS_LOAD, addr_tbl[i], '0);
        wait_done();
        check_value("d_rdata", d_rdata, exp_tbl[i]);
        check_single_done();
      end
      default: begin
        fetch_addr.raw = addr_tbl[i];
        issue_data(BUS_LOAD, wdata_tbl[i], '0);
        // first acceptance after capture must be the data side
        @(negedge clock);
        while (!(proc2mem_command != BUS_NONE && mem2proc_response != '0)) @(negedge clock);
        check_value("proc2mem_addr", proc2mem_addr, d_addr);
        wait_done();
        check_value("d_rdata", d_rdata, line_pattern(d_addr));
        wait_fetch();
        check_value("fetch_inst", fetch_inst, exp_tbl[i]);
      end
    endcase
  endtask

  // a refused command must come back unchanged
  // unless the data side took the bus over
  always @(negedge clock) begin
    if (reset) begin
      held_q = 1'b0;
    end else begin
      if (held_q) begin
        assert ((proc2mem_command == held_cmd && proc2mem_addr == held_addr) ||
                (d_busy && proc2mem_command == d_cmd && proc2mem_addr == d_addr)) else begin
          error_count++;
          $display("** Error: proc2mem_addr = %h, expected %h (held command changed)",
                   proc2mem_addr, held_addr);
        end
      end
      if (proc2mem_command == BUS_STORE) begin
        check_value("proc2mem_data", proc2mem_data, d_wdata);   // store word on the bus
      end
      held_q    = (proc2mem_command != BUS_NONE) && (mem2proc_response == '0);
      held_cmd  = proc2mem_command;
      held_addr = proc2mem_addr;
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    fetch_addr.raw = '0;
    d_req          = 1'b0;
    d_cmd          = BUS_NONE;
    d_addr         = '0;
    d_wdata        = '0;
    error_count    = 0;
    cycle_count    = 0;
    n_entries      = 0;
    held_q         = 1'b0;

    add_entry(K_FETCH, 64'h0000_0004, '0, inst_of(64'h0000_0004));
    add_entry(K_FETCH, 64'h0000_1238, '0, inst_of(64'h0000_1238));
    add_entry(K_HIT,   64'h0000_123c, '0, inst_of(64'h0000_123c));
    add_entry(K_HIT,   64'h0000_1238, '0, inst_of(64'h0000_1238));
    add_entry(K_FETCH, 64'h0000_2450, '0, inst_of(64'h0000_2450));
    add_entry(K_STORE, 64'h0000_8040, 64'h0123_4567_89ab_cdef, '0);
    add_entry(K_LOAD,  64'h0000_8040, '0, 64'h0123_4567_89ab_cdef);
    add_entry(K_LOAD,  64'h0000_8100, '0, line_pattern(64'h0000_8100));
    add_entry(K_RACE,  64'h0000_3360, 64'h0000_9008, inst_of(64'h0000_3360));
    add_entry(K_HIT,   64'h0000_3364, '0, inst_of(64'h0000_3364));
    add_entry(K_STORE, 64'h0000_8048, 64'hdead_beef_0bad_f00d, '0);
    add_entry(K_LOAD,  64'h0000_8048, '0, 64'hdead_beef_0bad_f00d);
    add_entry(K_FETCH, 64'h0000_4238, '0, inst_of(64'h0000_4238));   // evicts index 7
    add_entry(K_FETCH, 64'h0000_123c, '0, inst_of(64'h0000_123c));

    @(negedge reset);
    @(negedge clock);
    check_value("proc2mem_command", proc2mem_command, BUS_NONE);
    check_value("d_busy", d_busy, 1'b0);
    check_value("d_done", d_done, 1'b0);
    check_value("fetch_valid", fetch_valid, 1'b0);

    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end

    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model import fetch_mem_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [1:0]           proc2mem_command,
  input  logic [ADDR_W-1:0]    proc2mem_addr,
  input  logic [DATA_W-1:0]    proc2mem_data,
  output logic [MEM_TAG_W-1:0] mem2proc_response,
  output logic [MEM_TAG_W-1:0] mem2proc_tag,
  output logic [DATA_W-1:0]    mem2proc_data
);

  localparam int RET_DELAY = 4;

  integer               seed;
  logic [MEM_TAG_W-1:0] next_tag;
  logic                 line_written [64];
  logic [ADDR_W-1:0]    line_owner   [64];   // full line address of the stored word
  logic [DATA_W-1:0]    line_word    [64];
  logic [MEM_TAG_W-1:0] pipe_tag  [RET_DELAY];
  logic [DATA_W-1:0]    pipe_data [RET_DELAY];

  function automatic logic [DATA_W-1:0] read_line(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] line_a;
    line_a = {addr[ADDR_W-1:3], 3'b000};
    if (line_written[addr[8:3]] && line_owner[addr[8:3]] == line_a) begin
      return line_word[addr[8:3]];
    end
    return {~line_a[31:0], line_a[31:0]};   // unwritten line
  endfunction

  task automatic write_line(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    line_written[addr[8:3]] = 1'b1;
    line_owner[addr[8:3]]   = {addr[ADDR_W-1:3], 3'b000};
    line_word[addr[8:3]]    = data;
  endtask

  initial begin
    seed              = 32'h357c;
    next_tag          = 4'd1;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    for (int i = 0; i < 64; i++) begin
      line_written[i] = 1'b0;
    end
    for (int i = 0; i < RET_DELAY; i++) begin
      pipe_tag[i]  = '0;
      pipe_data[i] = '0;
    end
  end

  always @(posedge clock) begin
    #1;
    if (reset) begin
      mem2proc_response = '0;
      mem2proc_tag      = '0;
      mem2proc_data     = '0;
      for (int i = 0; i < RET_DELAY; i++) begin
        pipe_tag[i] = '0;
      end
    end else begin
      mem2proc_tag  = pipe_tag[RET_DELAY-1];   // oldest load comes back
      mem2proc_data = (pipe_tag[RET_DELAY-1] != '0) ? pipe_data[RET_DELAY-1] : '0;
      for (int i = RET_DELAY - 1; i > 0; i--) begin
        pipe_tag[i]  = pipe_tag[i-1];
        pipe_data[i] = pipe_data[i-1];
      end
      pipe_tag[0]       = '0;
      mem2proc_response = '0;
      // roughly one held cycle in four is refused
      if (proc2mem_command != BUS_NONE && ($random(seed) & 3) != 0) begin
        mem2proc_response = next_tag;
        if (proc2mem_command == BUS_LOAD) begin
          pipe_tag[0]  = next_tag;
          pipe_data[0] = read_line(proc2mem_addr);
        end else if (proc2mem_command == BUS_STORE) begin
          write_line(proc2mem_addr, proc2mem_data);
        end
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;   // 100 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

// ==== hw/fetch_mem_top.sv ====
`timescale 1ns/1ps

module fetch_mem_top import fetch_mem_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // instruction side
  input  icache_addr_u         fetch_addr,
  output logic [INST_W-1:0]    fetch_inst,
  output logic                 fetch_valid,
  // uncached data side
  input  logic                 d_req,
  input  logic [1:0]           d_cmd,
  input  logic [ADDR_W-1:0]    d_addr,
  input  logic [DATA_W-1:0]    d_wdata,
  output logic                 d_busy,
  output logic                 d_done,
  output logic [DATA_W-1:0]    d_rdata,
  // memory
  input  logic [MEM_TAG_W-1:0] mem2proc_response,
  input  logic [DATA_W-1:0]    mem2proc_data,
  input  logic [MEM_TAG_W-1:0] mem2proc_tag,
  output logic [1:0]           proc2mem_command,
  output logic [ADDR_W-1:0]    proc2mem_addr,
  output logic [DATA_W-1:0]    proc2mem_data
);

  logic                    rd_hit;
  logic [DATA_W-1:0]       rd_data;
  logic                    fill_en;
  logic [ICACHE_IDX_W-1:0] fill_idx;
  logic [ICACHE_TAG_W-1:0] fill_tag;
  logic [DATA_W-1:0]       fill_data;
  logic [1:0]              imem_command;
  logic [ADDR_W-1:0]       imem_addr;
  logic [MEM_TAG_W-1:0]    imem_response;   // zero while data side holds the bus

  icache_lines lines_0 (
    .clock      (clock),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .fill_en    (fill_en),
    .fill_idx   (fill_idx),
    .fill_tag   (fill_tag),
    .fill_data  (fill_data),
    .rd_hit     (rd_hit),
    .rd_data    (rd_data)
  );

  icache_miss_tracker tracker_0 (
    .clock         (clock),
    .reset         (reset),
    .fetch_addr    (fetch_addr),
    .rd_hit        (rd_hit),
    .rd_data       (rd_data),
    .imem_response (imem_response),
    .mem2proc_tag  (mem2proc_tag),
    .mem2proc_data (mem2proc_data),
    .fetch_inst    (fetch_inst),
    .fetch_valid   (fetch_valid),
    .imem_command  (imem_command),
    .imem_addr     (imem_addr),
    .fill_en       (fill_en),
    .fill_idx      (fill_idx),
    .fill_tag      (fill_tag),
    .fill_data     (fill_data)
  );

  mem_bus_port bus_0 (
    .clock             (clock),
    .reset             (reset),
    .d_req             (d_req),
    .d_cmd             (d_cmd),
    .d_addr            (d_addr),
    .d_wdata           (d_wdata),
    .imem_command      (imem_command),
    .imem_addr         (imem_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .d_busy            (d_busy),
    .d_done            (d_done),
    .d_rdata           (d_rdata),
    .imem_response     (imem_response),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data)
  );

endmodule

// ==== hw/mem_bus_port.sv ====
`timescale 1ns/1ps

module mem_bus_port import fetch_mem_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 d_req,
  input  logic [1:0]           d_cmd,
  input  logic [ADDR_W-1:0]    d_addr,
  input  logic [DATA_W-1:0]    d_wdata,
  input  logic [1:0]           imem_command,
  input  logic [ADDR_W-1:0]    imem_addr,
  input  logic [MEM_TAG_W-1:0] mem2proc_response,
  input  logic [MEM_TAG_W-1:0] mem2proc_tag,
  input  logic [DATA_W-1:0]    mem2proc_data,
  output logic                 d_busy,
  output logic                 d_done,
  output logic [DATA_W-1:0]    d_rdata,
  output logic [MEM_TAG_W-1:0] imem_response,
  output logic [1:0]           proc2mem_command,
  output logic [ADDR_W-1:0]    proc2mem_addr,
  output logic [DATA_W-1:0]    proc2mem_data
);

  logic                 d_pending;   // captured, waiting for acceptance
  logic                 d_wait;      // load accepted, waiting for its tag
  logic [1:0]           d_cmd_q;
  logic [ADDR_W-1:0]    d_addr_q;
  logic [DATA_W-1:0]    d_wdata_q;
  logic [MEM_TAG_W-1:0] d_tag_q;

  logic d_capture;
  logic d_accept;
  logic d_return;

  assign d_capture = !d_busy && d_req && (d_cmd != BUS_NONE);
  assign d_accept  = d_pending && (mem2proc_response != '0);
  assign d_return  = d_wait && (mem2proc_tag == d_tag_q);

  // data side wins the bus whenever it has something unaccepted
  assign proc2mem_command = d_pending ? d_cmd_q  : imem_command;
  assign proc2mem_addr    = d_pending ? d_addr_q : imem_addr;
  assign proc2mem_data    = d_wdata_q;   // only stores carry data
  assign imem_response    = d_pending ? '0 : mem2proc_response;

  always_ff @(posedge clock) begin
    if (reset) begin
      d_busy    <= 1'b0;
      d_pending <= 1'b0;
      d_wait    <= 1'b0;
      d_done    <= 1'b0;
    end else begin
      d_done <= 1'b0;   // single cycle pulse
      if (d_capture) begin
        d_busy    <= 1'b1;
        d_pending <= 1'b1;
      end
      if (d_accept) begin
        d_pending <= 1'b0;
        if (d_cmd_q == BUS_STORE) begin
          d_done <= 1'b1;
          d_busy <= 1'b0;
        end else begin
          d_wait <= 1'b1;
        end
      end
      if (d_return) begin
        d_wait <= 1'b0;
        d_done <= 1'b1;
        d_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (d_capture) begin
      d_cmd_q   <= d_cmd;
      d_addr_q  <= d_addr;
      d_wdata_q <= d_wdata;
    end
    if (d_accept) begin
      d_tag_q <= mem2proc_response;   // tag of a load
    end
    if (d_return) begin
      d_rdata <= mem2proc_data;
    end
  end

  // done ends a busy period and busy drops with it
  a_done_ends_busy: assert property (
    @(posedge clock) disable iff (reset)
    d_done |-> !d_busy && $past(d_busy)
  );

  a_d_addr_stable: assert property (
    @(posedge clock) disable iff (reset)
    d_pending && mem2proc_response == '0 |=>
      d_pending && $stable(proc2mem_addr) && $stable(proc2mem_command)
  );

endmodule

// ==== hw/icache_miss_tracker.sv ====
`timescale 1ns/1ps

module icache_miss_tracker import fetch_mem_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  icache_addr_u            fetch_addr,
  input  logic                    rd_hit,
  input  logic [DATA_W-1:0]       rd_data,
  input  logic [MEM_TAG_W-1:0]    imem_response,
  input  logic [MEM_TAG_W-1:0]    mem2proc_tag,
  input  logic [DATA_W-1:0]       mem2proc_data,
  output logic [INST_W-1:0]       fetch_inst,
  output logic                    fetch_valid,
  output logic [1:0]              imem_command,
  output logic [ADDR_W-1:0]       imem_addr,
  output logic                    fill_en,
  output logic [ICACHE_IDX_W-1:0] fill_idx,
  output logic [ICACHE_TAG_W-1:0] fill_tag,
  output logic [DATA_W-1:0]       fill_data
);

  // memory tag table indexed by the tag memory handed out
  logic [NUM_MEM_TAGS-1:0] tbl_valid;
  logic [ICACHE_IDX_W-1:0] tbl_idx [NUM_MEM_TAGS];
  logic [ICACHE_TAG_W-1:0] tbl_tag [NUM_MEM_TAGS];

  // outstanding line request not yet accepted
  logic         req_active;
  icache_addr_u req_addr;
  icache_addr_u line_addr;

  logic in_table;
  logic start_miss;
  logic req_accept;
  logic fill_hit;

  // pick the instruction half
  assign fetch_inst  = fetch_addr.f.offset[2] ? rd_data[DATA_W-1:INST_W] : rd_data[INST_W-1:0];
  assign fetch_valid = rd_hit;

  always_comb begin
    line_addr          = fetch_addr;
    line_addr.f.offset = '0;   // whole line
  end

  // is this line already on its way back
  always_comb begin
    in_table = 1'b0;
    for (int t = 1; t < NUM_MEM_TAGS; t++) begin
      if (tbl_valid[t] && tbl_idx[t] == fetch_addr.f.idx && tbl_tag[t] == fetch_addr.f.tag) begin
        in_table = 1'b1;
      end
    end
  end

  assign start_miss    = !req_active && !rd_hit && !in_table;
  assign req_accept    = req_active && (imem_response != '0);

  assign imem_command = req_active ? BUS_LOAD : BUS_NONE;
  assign imem_addr    = req_addr.raw;

  // returning tag that belongs to us becomes a fill
  assign fill_hit  = (mem2proc_tag != '0) && tbl_valid[mem2proc_tag];
  assign fill_en   = fill_hit;
  assign fill_idx  = tbl_idx[mem2proc_tag];
  assign fill_tag  = tbl_tag[mem2proc_tag];
  assign fill_data = mem2proc_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      req_active <= 1'b0;
      tbl_valid  <= '0;
    end else begin
      if (fill_hit) begin
        tbl_valid[mem2proc_tag] <= 1'b0;
      end
      if (req_accept) begin
        req_active               <= 1'b0;
        tbl_valid[imem_response] <= 1'b1;
      end else if (start_miss) begin
        req_active <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start_miss) begin
      req_addr <= line_addr;
    end
    if (req_accept) begin
      tbl_idx[imem_response] <= req_addr.f.idx;
      tbl_tag[imem_response] <= req_addr.f.tag;
    end
  end

  // held request keeps its line until the bus takes it
  a_req_stable: assert property (
    @(posedge clock) disable iff (reset)
    req_active && imem_response == '0 |=> req_active && $stable(req_addr)
  );

  // memory must not hand out a tag that is still outstanding
  a_tag_free: assert property (
    @(posedge clock) disable iff (reset)
    req_accept |-> !tbl_valid[imem_response]
  );

endmodule

// ==== hw/icache_lines.sv ====
`timescale 1ns/1ps

module icache_lines import fetch_mem_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  icache_addr_u            fetch_addr,
  input  logic                    fill_en,
  input  logic [ICACHE_IDX_W-1:0] fill_idx,
  input  logic [ICACHE_TAG_W-1:0] fill_tag,
  input  logic [DATA_W-1:0]       fill_data,
  output logic                    rd_hit,
  output logic [DATA_W-1:0]       rd_data
);

  logic [NUM_ICACHE_LINES-1:0] line_valid;
  logic [ICACHE_TAG_W-1:0]     line_tag  [NUM_ICACHE_LINES];
  logic [DATA_W-1:0]           line_data [NUM_ICACHE_LINES];

  logic [ICACHE_IDX_W-1:0] rd_idx;
  logic [ICACHE_TAG_W-1:0] rd_tag;

  assign rd_idx = fetch_addr.f.idx;
  assign rd_tag = fetch_addr.f.tag;

  // lookup is purely combinational
  assign rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
  assign rd_data = line_data[rd_idx];

  // a fill sets the line valid
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (fill_en) begin
      line_valid[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_en) begin
      line_tag[fill_idx]  <= fill_tag;   // new owner of the set
      line_data[fill_idx] <= fill_data;
    end
  end

  // fill port is driven from the miss tracker's tag table and the
  // returning bus data, so anything unknown here means a table entry
  // was used without having been written
  a_fill_known: assert property (
    @(posedge clock) disable iff (reset)
    fill_en |-> !$isunknown({fill_idx, fill_tag, fill_data})
  );

endmodule

// ==== hw/fetch_mem_pkg.sv ====
package fetch_mem_pkg;

  // memory bus widths
  localparam int ADDR_W    = 64;
  localparam int DATA_W    = 64;
  localparam int INST_W    = 32;
  localparam int MEM_TAG_W = 4;

  // tag 0 is never handed out, so entry 0 stays empty
  localparam int NUM_MEM_TAGS = 16;

  // direct mapped icache geometry
  localparam int NUM_ICACHE_LINES = 32;
  localparam int ICACHE_IDX_W     = 5;
  localparam int ICACHE_TAG_W     = 8;
  localparam int ICACHE_OFFSET_W  = 3;

  localparam int ICACHE_UNUSED_W = ADDR_W - ICACHE_TAG_W - ICACHE_IDX_W - ICACHE_OFFSET_W;

  // bus commands
  localparam logic [1:0] BUS_NONE  = 2'd0;
  localparam logic [1:0] BUS_LOAD  = 2'd1;
  localparam logic [1:0] BUS_STORE = 2'd2;

  // one address word, seen either raw or split into cache fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [ICACHE_UNUSED_W-1:0] unused;   // above the line tag, ignored
      logic [ICACHE_TAG_W-1:0]    tag;
      logic [ICACHE_IDX_W-1:0]    idx;
      logic [ICACHE_OFFSET_W-1:0] offset;   // bit 2 picks the upper instruction
    } f;
  } icache_addr_u;

endpackage
